// File: common/ooo_pkg.sv
package ooo_pkg;

	// Machine width and structure sizes
	localparam int SS_SIZE   = 2;
	localparam int ROB_SIZE  = 8;
	localparam int ROB_IDX_W = 3;

	localparam int ARCH_REGS = 8; // r0 is a normal register
	localparam int ARCH_W    = 3;
	localparam int PHYS_REGS = 32;
	localparam int PHYS_W    = 5;

	// Tags not held by the architectural map
	localparam int FREE_SIZE = PHYS_REGS - ARCH_REGS;

	localparam logic [31:0] NOOP_INST = 32'h47ff_041f;

	typedef struct packed {
		logic              ready;
		logic [PHYS_W-1:0] tag;
	} phys_reg_t;

	typedef struct packed {
		logic              valid;
		logic              halt;
		logic [ARCH_W-1:0] dest;
		logic [31:0]       inst;
		logic [31:0]       npc;
	} dispatch_pkt_t;

	// busy doubles as valid on the retire outputs
	typedef struct packed {
		logic              busy;
		logic              halt;
		logic [ARCH_W-1:0] dest;
		phys_reg_t         t_new;
		logic [PHYS_W-1:0] t_old;
		logic [31:0]       inst;
		logic [31:0]       npc;
	} rob_row_t;

	typedef struct packed {
		logic              valid;
		logic [PHYS_W-1:0] tag;
	} cdb_pkt_t;

endpackage

// File: hdl/tag_cam.sv
`timescale 1ns/1ps

module tag_cam #(
	parameter int LENGTH   = 8,
	parameter int NUM_TAGS = 2,
	parameter int TAG_SIZE = 5
) (
	input  logic [NUM_TAGS-1:0][TAG_SIZE-1:0] tags,
	input  logic [NUM_TAGS-1:0]               enable,
	input  logic [LENGTH-1:0][TAG_SIZE-1:0]   table_in,
	output logic [LENGTH-1:0][NUM_TAGS-1:0]   hits
);

	// Full cross-compare, one comparator per entry and lane
	always_comb begin
		for (int i = 0; i < LENGTH; i++) begin
			for (int j = 0; j < NUM_TAGS; j++) begin
				hits[i][j] = enable[j] && (tags[j] == table_in[i]);
			end
		end
	end

endmodule

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
	input  logic                                                clock,
	input  logic                                                rst,
	input  logic                                                flush,
	input  ooo_pkg::dispatch_pkt_t [ooo_pkg::SS_SIZE-1:0]       dispatch_go,
	input  logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0]    t_new_in,
	input  logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0]    t_old_in,
	input  ooo_pkg::cdb_pkt_t [ooo_pkg::SS_SIZE-1:0]            cdb,
	output ooo_pkg::rob_row_t [ooo_pkg::SS_SIZE-1:0]            retire,
	output logic                                                has_room
);

	import ooo_pkg::*;

	rob_row_t [ROB_SIZE-1:0] rows;
	rob_row_t [ROB_SIZE-1:0] rows_next;
	rob_row_t                clear_row;

	// head points at the last retired row, tail at the last dispatched one
	logic [ROB_IDX_W-1:0] head;
	logic [ROB_IDX_W-1:0] tail;
	logic [ROB_IDX_W-1:0] head_next;
	logic [ROB_IDX_W-1:0] tail_next;
	logic [ROB_IDX_W:0]   free_rows;
	logic [ROB_IDX_W:0]   free_rows_next;

	logic [ROB_IDX_W-1:0] ret_idx;
	logic [ROB_IDX_W-1:0] disp_idx;
	logic                 ret_stop;
	logic [ROB_IDX_W:0]   n_ret;
	logic [ROB_IDX_W:0]   n_disp;

	logic [SS_SIZE-1:0][PHYS_W-1:0]  cam_tags;
	logic [SS_SIZE-1:0]              cam_en;
	logic [ROB_SIZE-1:0][PHYS_W-1:0] cam_table;
	logic [ROB_SIZE-1:0][SS_SIZE-1:0] cam_hits;
	logic [ROB_SIZE-1:0]             row_ready;

	assign clear_row = '{
		busy:  1'b0,
		halt:  1'b0,
		dest:  '0,
		t_new: '0,
		t_old: '0,
		inst:  NOOP_INST,
		npc:   '0
	};

	always_comb begin
		for (int j = 0; j < SS_SIZE; j++) begin
			cam_tags[j] = cdb[j].tag;
			cam_en[j]   = cdb[j].valid;
		end
		for (int i = 0; i < ROB_SIZE; i++) begin
			cam_table[i] = rows[i].t_new.tag;
		end
	end

	tag_cam #(
		.LENGTH   (ROB_SIZE),
		.NUM_TAGS (SS_SIZE),
		.TAG_SIZE (PHYS_W)
	) u_cdb_cam (
		.tags     (cam_tags),
		.enable   (cam_en),
		.table_in (cam_table),
		.hits     (cam_hits)
	);

	// Ready now, or completing on the CDB this cycle
	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			row_ready[i] = rows[i].busy && (rows[i].t_new.ready || (|cam_hits[i]));
		end
	end

	always_comb begin
		rows_next = rows;
		n_ret     = '0;
		n_disp    = '0;
		ret_stop  = 1'b0;
		ret_idx   = head;
		disp_idx  = tail;

		for (int i = 0; i < ROB_SIZE; i++) begin
			if (rows[i].busy && (|cam_hits[i]))
				rows_next[i].t_new.ready = 1'b1;
		end

		// Oldest first, stop at the first row still waiting
		for (int i = 0; i < SS_SIZE; i++) begin
			ret_idx   = ret_idx + 1'b1;
			retire[i] = clear_row;
			if (!ret_stop && row_ready[ret_idx]) begin
				retire[i]               = rows_next[ret_idx];
				rows_next[ret_idx].busy = 1'b0;
				n_ret                   = n_ret + 1'b1;
			end else begin
				ret_stop = 1'b1;
			end
		end

		// Valid slots packed in order after the tail
		for (int i = 0; i < SS_SIZE; i++) begin
			if (dispatch_go[i].valid) begin
				disp_idx            = disp_idx + 1'b1;
				rows_next[disp_idx] = '{
					busy:  1'b1,
					halt:  dispatch_go[i].halt,
					dest:  dispatch_go[i].dest,
					t_new: '{ready: 1'b0, tag: t_new_in[i]},
					t_old: t_old_in[i],
					inst:  dispatch_go[i].inst,
					npc:   dispatch_go[i].npc
				};
				n_disp = n_disp + 1'b1;
			end
		end

		head_next      = head + n_ret[ROB_IDX_W-1:0];
		tail_next      = disp_idx;
		free_rows_next = free_rows + n_ret - n_disp;
	end

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			for (int i = 0; i < ROB_SIZE; i++) begin
				rows[i] <= clear_row;
			end
			head      <= ROB_IDX_W'(ROB_SIZE - 1);
			tail      <= ROB_IDX_W'(ROB_SIZE - 1);
			free_rows <= (ROB_IDX_W + 1)'(ROB_SIZE);
		end else begin
			rows      <= rows_next;
			head      <= head_next;
			tail      <= tail_next;
			free_rows <= free_rows_next;
		end
	end

	assign has_room = free_rows >= (ROB_IDX_W + 1)'(SS_SIZE); // Room for a full group

endmodule

// File: hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
	input  logic                                             clock,
	input  logic                                             rst,
	input  logic                                             flush,
	input  logic [ooo_pkg::SS_SIZE-1:0]                      alloc,
	input  logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0] release_tag,
	input  logic [ooo_pkg::SS_SIZE-1:0]                      release_valid,
	output logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0] alloc_tag,
	output logic                                             has_room
);

	import ooo_pkg::*;

	logic [FREE_SIZE-1:0][PHYS_W-1:0] queue;

	// The tail always sits on the retired head; a retiring instruction
	// hands back T_old into the slot its own T_new came from
	logic [PHYS_W-1:0] spec_head;
	logic [PHYS_W-1:0] ret_head;
	logic [PHYS_W-1:0] spec_head_next;
	logic [PHYS_W-1:0] ret_head_next;
	logic [PHYS_W-1:0] count;
	logic [PHYS_W-1:0] n_alloc;
	logic [PHYS_W-1:0] n_rel;
	logic [SS_SIZE-1:0][PHYS_W-1:0] wr_ptr;

	function automatic logic [PHYS_W-1:0] ptr_inc(input logic [PHYS_W-1:0] p);
		return (p == PHYS_W'(FREE_SIZE - 1)) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		spec_head_next = spec_head;
		n_alloc        = '0;
		for (int i = 0; i < SS_SIZE; i++) begin
			alloc_tag[i] = queue[spec_head_next];
			if (alloc[i]) begin
				spec_head_next = ptr_inc(spec_head_next);
				n_alloc        = n_alloc + 1'b1;
			end
		end
	end

	always_comb begin
		ret_head_next = ret_head;
		n_rel         = '0;
		for (int i = 0; i < SS_SIZE; i++) begin
			wr_ptr[i] = ret_head_next;
			if (release_valid[i]) begin
				ret_head_next = ptr_inc(ret_head_next);
				n_rel         = n_rel + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < FREE_SIZE; i++) begin
				queue[i] <= PHYS_W'(i + ARCH_REGS); // Tags 8 to 31
			end
		end else begin
			for (int i = 0; i < SS_SIZE; i++) begin
				if (release_valid[i])
					queue[wr_ptr[i]] <= release_tag[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			spec_head <= '0;
			ret_head  <= '0;
			count     <= PHYS_W'(FREE_SIZE);
		end else if (flush) begin
			// Everything past the retired head is free again
			spec_head <= ret_head_next;
			ret_head  <= ret_head_next;
			count     <= PHYS_W'(FREE_SIZE);
		end else begin
			spec_head <= spec_head_next;
			ret_head  <= ret_head_next;
			count     <= count - n_alloc + n_rel;
		end
	end

	assign has_room = count >= PHYS_W'(SS_SIZE);

endmodule

// File: hdl/map_table.sv
`timescale 1ns/1ps

module map_table (
	input  logic                                             clock,
	input  logic                                             rst,
	input  logic                                             flush,
	input  ooo_pkg::dispatch_pkt_t [ooo_pkg::SS_SIZE-1:0]    dispatch_go,
	input  logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0] alloc_tag,
	input  ooo_pkg::rob_row_t [ooo_pkg::SS_SIZE-1:0]         retire,
	output logic [ooo_pkg::SS_SIZE-1:0][ooo_pkg::PHYS_W-1:0] t_old
);

	import ooo_pkg::*;

	logic [ARCH_REGS-1:0][PHYS_W-1:0] spec_map;
	logic [ARCH_REGS-1:0][PHYS_W-1:0] arch_map;
	logic [ARCH_REGS-1:0][PHYS_W-1:0] spec_next;
	logic [ARCH_REGS-1:0][PHYS_W-1:0] arch_next;

	// Younger slot sees an older slot's new tag on the same dest
	always_comb begin
		for (int i = 0; i < SS_SIZE; i++) begin
			t_old[i] = spec_map[dispatch_go[i].dest];
			for (int j = 0; j < i; j++) begin
				if (dispatch_go[j].valid && (dispatch_go[j].dest == dispatch_go[i].dest))
					t_old[i] = alloc_tag[j];
			end
		end
	end

	always_comb begin
		arch_next = arch_map;
		for (int i = 0; i < SS_SIZE; i++) begin
			if (retire[i].busy)
				arch_next[retire[i].dest] = retire[i].t_new.tag; // Age order
		end

		spec_next = spec_map;
		if (flush) begin
			spec_next = arch_next;
		end else begin
			for (int i = 0; i < SS_SIZE; i++) begin
				if (dispatch_go[i].valid)
					spec_next[dispatch_go[i].dest] = alloc_tag[i];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				spec_map[i] <= PHYS_W'(i); // Identity map
				arch_map[i] <= PHYS_W'(i);
			end
		end else begin
			spec_map <= spec_next;
			arch_map <= arch_next;
		end
	end

endmodule

// File: hdl/rename_commit_top.sv
`timescale 1ns/1ps

module rename_commit_top (
	input  logic                                          clock,
	input  logic                                          rst,
	input  ooo_pkg::dispatch_pkt_t [ooo_pkg::SS_SIZE-1:0] dispatch,
	input  ooo_pkg::cdb_pkt_t [ooo_pkg::SS_SIZE-1:0]      cdb,
	input  logic                                          branch_not_taken,
	output logic                                          dispatch_ready,
	output ooo_pkg::rob_row_t [ooo_pkg::SS_SIZE-1:0]      retire,
	output logic                                          halted
);

	import ooo_pkg::*;

	dispatch_pkt_t [SS_SIZE-1:0]    dispatch_go;
	logic [SS_SIZE-1:0]             alloc;
	logic [SS_SIZE-1:0][PHYS_W-1:0] alloc_tag;
	logic [SS_SIZE-1:0][PHYS_W-1:0] t_old;
	logic [SS_SIZE-1:0][PHYS_W-1:0] release_tag;
	logic [SS_SIZE-1:0]             release_valid;
	logic [SS_SIZE-1:0]             retire_halt;
	logic                           rob_room;
	logic                           fl_room;

	// Both from registered counts, so no path back from dispatch
	assign dispatch_ready = rob_room && fl_room;

	always_comb begin
		for (int i = 0; i < SS_SIZE; i++) begin
			dispatch_go[i]       = dispatch[i];
			dispatch_go[i].valid = dispatch[i].valid && dispatch_ready;
			alloc[i]             = dispatch_go[i].valid;
			release_tag[i]       = retire[i].t_old;
			release_valid[i]     = retire[i].busy;
			retire_halt[i]       = retire[i].busy && retire[i].halt;
		end
	end

	assign halted = |retire_halt;

	reorder_buffer u_rob (
		.clock       (clock),
		.rst         (rst),
		.flush       (branch_not_taken),
		.dispatch_go (dispatch_go),
		.t_new_in    (alloc_tag),
		.t_old_in    (t_old),
		.cdb         (cdb),
		.retire      (retire),
		.has_room    (rob_room)
	);

	free_list u_free_list (
		.clock         (clock),
		.rst           (rst),
		.flush         (branch_not_taken),
		.alloc         (alloc),
		.release_tag   (release_tag),
		.release_valid (release_valid),
		.alloc_tag     (alloc_tag),
		.has_room      (fl_room)
	);

	map_table u_map_table (
		.clock       (clock),
		.rst         (rst),
		.flush       (branch_not_taken),
		.dispatch_go (dispatch_go),
		.alloc_tag   (alloc_tag),
		.retire      (retire),
		.t_old       (t_old)
	);

endmodule

// File: sim/tb_rename_commit.sv
`timescale 1ns/1ps

module tb_rename_commit;

	import ooo_pkg::*;

	typedef struct packed {
		logic              halt;
		logic [ARCH_W-1:0] dest;
		logic [PHYS_W-1:0] t_new;
		logic [PHYS_W-1:0] t_old;
		logic [31:0]       inst;
		logic              done;
	} entry_t;

	logic                        clock = 1'b0;
	logic                        rst;
	dispatch_pkt_t [SS_SIZE-1:0] dispatch;
	cdb_pkt_t [SS_SIZE-1:0]      cdb;
	logic                        branch_not_taken;
	logic                        dispatch_ready;
	rob_row_t [SS_SIZE-1:0]      retire;
	logic                        halted;

	// Reference model of the free FIFO, both maps and the outstanding rows
	logic [PHYS_W-1:0] free_q [FREE_SIZE];
	logic [PHYS_W-1:0] spec_map [ARCH_REGS];
	logic [PHYS_W-1:0] arch_map [ARCH_REGS];
	int                spec_h;
	int                ret_h;
	entry_t            pend [$];

	logic [31:0]       seed = 32'hd9d8_aaba;
	int                passes = 0;
	int                fails = 0;
	int                f0 = 0;
	int                tests_failed = 0;
	int                dual_cnt = 0;
	int                halt_cnt = 0;
	int                n0;
	logic [ARCH_W-1:0] d;
	logic [PHYS_W-1:0] flushed_t0;
	logic [PHYS_W-1:0] flushed_t1;

	rename_commit_top DUT (.*);

	always #5 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [ARCH_W-1:0] rand_reg();
		return ARCH_W'(lcg_next() >> 29); // Upper bits are the better ones
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) passes++;
		else begin
			fails++;
			$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, got);
		end
	endtask

	task automatic report_test(input string name);
		if (fails == f0) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, fails - f0);
		end
		f0 = fails;
	endtask

	// Slot 0 carries the older instruction
	task automatic send_group(input logic [1:0] v, input logic [ARCH_W-1:0] d0,
			input logic [ARCH_W-1:0] d1, input logic h0, input logic need_ready);
		int n;
		n = 0;
		while (need_ready && !dispatch_ready && n < 40) begin
			@(negedge clock);
			n++;
		end
		if (need_ready && !dispatch_ready) begin
			fails++;
			$display("Timed out after %0d cycles waiting for dispatch_ready", n);
		end
		dispatch[0] = '{valid: v[0], halt: h0, dest: d0, inst: lcg_next(), npc: 32'h100};
		dispatch[1] = '{valid: v[1], halt: 1'b0, dest: d1, inst: lcg_next(), npc: 32'h104};
		@(negedge clock);
		dispatch = '0;
	endtask

	task automatic broadcast(input logic [1:0] v, input logic [PHYS_W-1:0] t0,
			input logic [PHYS_W-1:0] t1);
		cdb[0] = '{valid: v[0], tag: t0};
		cdb[1] = '{valid: v[1], tag: t1};
		@(negedge clock);
		cdb = '0;
	endtask

	// Random completion order, random lane, then wait for the drain
	task automatic complete_all();
		logic [PHYS_W-1:0] tags [$];
		logic [PHYS_W-1:0] tmp;
		logic [31:0]       r;
		int                j;
		int                n;
		foreach (pend[k])
			if (!pend[k].done)
				tags.push_back(pend[k].t_new);
		while (tags.size() > 0) begin
			r = lcg_next();
			j = int'(r[30:16]) % tags.size();
			tmp = tags[j];
			tags.delete(j);
			broadcast(r[31] ? 2'b10 : 2'b01, tmp, tmp);
		end
		n = 0;
		while (pend.size() > 0 && n < 40) begin
			@(negedge clock);
			n++;
		end
		if (pend.size() > 0) begin
			fails++;
			$display("Timed out with %0d instructions still waiting to retire", pend.size());
		end
	endtask

	always @(posedge clock) begin : model_check
		entry_t e;
		int     n_exp;
		logic   exp_ready;
		logic   exp_halt;
		if (rst) begin
			foreach (free_q[i])
				free_q[i] = PHYS_W'(ARCH_REGS + i);
			foreach (spec_map[i])
				spec_map[i] = PHYS_W'(i);
			arch_map = spec_map;
			spec_h = 0;
			ret_h  = 0;
			pend.delete();
		end else begin
			exp_ready = (ROB_SIZE - pend.size()) >= SS_SIZE;
			check_val("dispatch_ready", exp_ready, dispatch_ready);
			// A CDB match counts in the same cycle
			foreach (pend[k])
				for (int l = 0; l < SS_SIZE; l++)
					if (cdb[l].valid && cdb[l].tag == pend[k].t_new)
						pend[k].done = 1'b1;
			n_exp = 0;
			while (n_exp < SS_SIZE && n_exp < pend.size() && pend[n_exp].done)
				n_exp++;
			exp_halt = 1'b0;
			for (int i = 0; i < SS_SIZE; i++) begin
				check_val($sformatf("retire[%0d].busy", i), i < n_exp, retire[i].busy);
				if (i < n_exp) begin
					e = pend.pop_front();
					check_val($sformatf("retire[%0d].dest", i), e.dest, retire[i].dest);
					check_val($sformatf("retire[%0d].t_new", i), e.t_new, retire[i].t_new.tag);
					check_val($sformatf("retire[%0d].t_old", i), e.t_old, retire[i].t_old);
					check_val($sformatf("retire[%0d].inst", i), e.inst, retire[i].inst);
					arch_map[e.dest] = e.t_new;
					free_q[ret_h] = e.t_old; // Tail of a full ring is the retired head
					ret_h = (ret_h + 1) % FREE_SIZE;
					exp_halt |= e.halt;
				end
			end
			check_val("halted", exp_halt, halted);
			dual_cnt += retire[0].busy && retire[1].busy;
			halt_cnt += halted;
			if (branch_not_taken) begin
				pend.delete();
				spec_map = arch_map;
				spec_h   = ret_h;
			end else if (exp_ready) begin
				for (int s = 0; s < SS_SIZE; s++) begin
					if (dispatch[s].valid) begin
						e = '{halt: dispatch[s].halt, dest: dispatch[s].dest,
							t_new: free_q[spec_h], t_old: spec_map[dispatch[s].dest],
							inst: dispatch[s].inst, done: 1'b0};
						spec_map[e.dest] = e.t_new; // Seen by the younger slot
						spec_h = (spec_h + 1) % FREE_SIZE;
						pend.push_back(e);
					end
				end
			end
		end
	end

	initial begin
		rst              = 1'b1;
		dispatch         = '0;
		cdb              = '0;
		branch_not_taken = 1'b0;
		repeat (10) @(negedge clock);
		rst = 1'b0;
		check_val("dispatch_ready", 1, dispatch_ready);
		check_val("retire[0].busy", 0, retire[0].busy);
		check_val("retire[1].busy", 0, retire[1].busy);
		check_val("halted", 0, halted);
		report_test("reset state");

		send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		d = rand_reg();
		send_group(2'b11, d, d, 1'b0, 1'b1); // Same dest in both slots
		complete_all();
		report_test("in-order retirement");

		n0 = dual_cnt;
		send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		broadcast(2'b01, pend[1].t_new, '0);
		check_val("retire[0].busy", 0, retire[0].busy); // Older row still waiting
		broadcast(2'b01, pend[0].t_new, '0);
		send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		broadcast(2'b11, pend[1].t_new, pend[0].t_new);
		check_val("two-wide retire cycles", n0 + 2, dual_cnt);
		complete_all();
		report_test("two-wide retirement");

		for (int g = 0; g < ROB_SIZE / SS_SIZE; g++)
			send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		check_val("dispatch_ready", 0, dispatch_ready);
		send_group(2'b11, rand_reg(), rand_reg(), 1'b1, 1'b0); // Dropped while full
		broadcast(2'b11, pend[0].t_new, pend[1].t_new);
		check_val("dispatch_ready", 1, dispatch_ready);
		complete_all();
		report_test("full reorder buffer");

		send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		send_group(2'b11, rand_reg(), rand_reg(), 1'b0, 1'b1);
		broadcast(2'b11, pend[0].t_new, pend[1].t_new);
		d = pend[0].dest;
		flushed_t0 = pend[0].t_new;
		flushed_t1 = pend[1].t_new;
		branch_not_taken = 1'b1;
		send_group(2'b11, d, d, 1'b0, 1'b0); // Loses to the flush
		branch_not_taken = 1'b0;
		broadcast(2'b11, flushed_t0, flushed_t1); // Cleared rows ignore the CDB
		send_group(2'b11, d, rand_reg(), 1'b0, 1'b1);
		complete_all();
		report_test("flush recovery");

		n0 = halt_cnt;
		send_group(2'b11, rand_reg(), rand_reg(), 1'b1, 1'b1);
		complete_all();
		check_val("halted cycles", n0 + 1, halt_cnt);
		report_test("halt");

		$display("Tests failed: %0d of 6, checks passed: %0d, checks failed: %0d",
			tests_failed, passes, fails);
		if (fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: filelist.f
common/ooo_pkg.sv
hdl/tag_cam.sv
rob/reorder_buffer.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/rename_commit_top.sv
sim/tb_rename_commit.sv

// File: Bender.yml
package:
  name: rename_commit

sources:
  - common/ooo_pkg.sv
  - hdl/tag_cam.sv
  - rob/reorder_buffer.sv
  - hdl/free_list.sv
  - hdl/map_table.sv
  - hdl/rename_commit_top.sv
  - target: simulation
    files:
      - sim/tb_rename_commit.sv
